/* project.f */
rtl/imul_pkg.sv
rtl/imul_dpath.sv
rtl/imul_ctrl.sv
rtl/imul_iterative.sv
tests/imul_tb.sv

/* Bender.yml */
package:
  name: imul_iterative

dependencies: {}

sources:
  # package first, then datapath and control, then the top level
  - rtl/imul_pkg.sv
  - rtl/imul_dpath.sv
  - rtl/imul_ctrl.sv
  - rtl/imul_iterative.sv

  # testbench, top module imul_tb
  - target: test
    files:
      - tests/imul_tb.sv

/* tests/imul_tb.sv */
/*
  corner and random signed products against a reference model with random back-pressure
  requests are offered back to back, so the next one always waits while the unit is busy
*/

module imul_tb;

  import imul_pkg::*;

  // --------------------------------------------------
  // test sizes and limits
  // --------------------------------------------------

  localparam int num_corners = 10;
  localparam int num_random  = 200;
  localparam int num_tests   = num_corners + num_random;
  // about 40 cycles per product plus margin for reset and drain
  localparam int cycle_limit = num_tests * 40 + 200;

  logic      clk;
  logic      reset;
  mul_req_t  req;
  logic      req_val;
  logic      req_rdy;
  mul_resp_t resp;
  logic      resp_val;
  logic      resp_rdy;

  integer    seed = 32'hfa56_3319;
  int        error_count;
  int        resp_count;
  int        cycle_count;

  // operands and back-pressure for each test
  logic [xlen-1:0] op_a [num_tests];
  logic [xlen-1:0] op_b [num_tests];
  int              hold_cycles [num_tests];

  // expected products and their operands in request order
  logic [prod_w-1:0] expect_q [$];
  mul_req_t          op_q [$];

  imul_iterative i_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // --------------------------------------------------
  // reference model and compare
  // --------------------------------------------------

  // full signed product with both operands sign extended first
  function automatic logic [prod_w-1:0] ref_mul(input logic signed [xlen-1:0] a,
                                                input logic signed [xlen-1:0] b);
    logic signed [prod_w-1:0] wide_a;
    logic signed [prod_w-1:0] wide_b;
    wide_a = a;
    wide_b = b;
    return wide_a * wide_b;
  endfunction

  task automatic check_value(input logic [prod_w-1:0] got, input logic [prod_w-1:0] expected,
                             input string what);
    if (got !== expected) begin
      error_count++;
      $display("Error at time %0t: %s, got %h expected %h", $time, what, got, expected);
    end
  endtask

  // edge cases first and then random pairs over all sign combinations
  task automatic make_operands();
    op_a[0] = 32'h0000_0000;
    op_b[0] = 32'h1234_5678;
    op_a[1] = 32'h8000_0000;
    op_b[1] = 32'h0000_0000;
    op_a[2] = 32'h0000_0001;
    op_b[2] = 32'hffff_ffff;
    // gives +2**31 and needs the magnitude read as unsigned
    op_a[3] = 32'h8000_0000;
    op_b[3] = 32'hffff_ffff;
    op_a[4] = 32'h8000_0000;
    op_b[4] = 32'h8000_0000;
    op_a[5] = 32'h7fff_ffff;
    op_b[5] = 32'h7fff_ffff;
    op_a[6] = 32'haaaa_aaaa;
    op_b[6] = 32'h5555_5555;
    op_a[7] = 32'h5555_5555;
    op_b[7] = 32'haaaa_aaaa;
    op_a[8] = 32'hffff_ffff;
    op_b[8] = 32'hffff_ffff;
    op_a[9] = 32'h7fff_ffff;
    op_b[9] = 32'h8000_0000;
    for (int i = num_corners; i < num_tests; i++) begin
      op_a[i] = $random(seed);
      op_b[i] = $random(seed);
    end
    // back-pressure of 0 to 7 cycles per response
    for (int i = 0; i < num_tests; i++) begin
      hold_cycles[i] = {$random(seed)} % 8;
    end
  endtask

  // --------------------------------------------------
  // request driver
  // --------------------------------------------------

  initial begin
    error_count = 0;
    req         = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    reset       = 1'b1;
    make_operands();
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // idle after reset with nothing pending and the accumulator cleared
    @(posedge clk);
    check_value(req_rdy, 1'b1, "req_rdy after reset");
    check_value(resp_val, 1'b0, "resp_val after reset");
    check_value(resp.result, '0, "result after reset");

    // next request goes up right after the previous accept and sits through calc
    for (int i = 0; i < num_tests; i++) begin
      req.a   <= op_a[i];
      req.b   <= op_b[i];
      req_val <= 1'b1;
      do begin
        @(posedge clk);
      end while (!req_rdy);
    end
    req_val <= 1'b0;

    while (resp_count < num_tests) begin
      @(posedge clk);
    end
    // a few idle cycles to catch a stray response
    repeat (4) @(posedge clk);
    check_value(resp_count, num_tests, "number of responses");
    check_value(expect_q.size(), 0, "expected results left in queue");

    $display("done: %0d responses, %0d errors", resp_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // --------------------------------------------------
  // response sink with back-pressure
  // --------------------------------------------------

  initial begin
    int resp_index;
    resp_index = 0;
    forever begin
      do begin
        @(posedge clk);
      end while (!resp_val);
      repeat (hold_cycles[resp_index % num_tests]) @(posedge clk);
      resp_rdy <= 1'b1;
      @(posedge clk);
      resp_rdy <= 1'b0;
      resp_index++;
    end
  end

  // --------------------------------------------------
  // monitor and checker
  // --------------------------------------------------

  int                edge_count;
  int                accept_edge;
  logic              resp_seen;
  logic              resp_taken;
  logic [prod_w-1:0] held_result;
  mul_req_t          taken_op;

  initial begin
    edge_count  = 0;
    accept_edge = 0;
    resp_seen   = 1'b0;
    resp_taken  = 1'b0;
    held_result = '0;
    resp_count  = 0;
  end

  // values read here are the ones present before the edge
  always @(posedge clk) begin
    if (!reset) begin
      // unit is idle again in the cycle right after a response transfer
      if (resp_taken) begin
        check_value(req_rdy, 1'b1, "req_rdy after response transfer");
      end
      resp_taken = 1'b0;
      if (req_val && req_rdy) begin
        // one operation at a time so the previous one must be taken
        check_value(expect_q.size(), 0, "request accepted while busy");
        expect_q.push_back(ref_mul(req.a, req.b));
        op_q.push_back(req);
        accept_edge = edge_count;
      end
      if (resp_val) begin
        if (!resp_seen) begin
          // resp_val rises after edge T+32 and is first seen at the edge after
          check_value(edge_count - accept_edge, xlen + 1, "accept to resp_val latency");
          held_result = resp.result;
          resp_seen   = 1'b1;
        end else begin
          check_value(resp.result, held_result, "resp changed under back-pressure");
        end
        check_value(req_rdy, 1'b0, "req_rdy high while a response is pending");
        if (resp_rdy) begin
          if (expect_q.size() == 0) begin
            error_count++;
            $display("response transfer at time %0t with no request outstanding", $time);
          end else begin
            taken_op = op_q.pop_front();
            check_value(resp.result, expect_q.pop_front(),
                        $sformatf("product of %0d and %0d",
                                  $signed(taken_op.a), $signed(taken_op.b)));
          end
          resp_count++;
          resp_seen  = 1'b0;
          resp_taken = 1'b1;
        end
      end else if (resp_seen) begin
        error_count++;
        $display("resp_val dropped at time %0t before the response was taken", $time);
        resp_seen = 1'b0;
      end
    end
    edge_count++;
  end

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles, %0d of %0d responses seen",
             cycle_limit, resp_count, num_tests);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* rtl/imul_iterative.sv */
/*
  signed 32x32 iterative multiplier, 64-bit product, valid/ready on both sides
  one operation in flight, 32 cycles from accept to resp_val
*/

module imul_iterative (
  input  logic                clk,
  input  logic                reset,

  // request side
  input  imul_pkg::mul_req_t  req,
  input  logic                req_val,
  output logic                req_rdy,

  // response side
  output imul_pkg::mul_resp_t resp,
  output logic                resp_val,
  input  logic                resp_rdy
);

  import imul_pkg::*;

  // --------------------------------------------------
  // control to datapath
  // --------------------------------------------------

  // capture operands, clear accumulator
  logic load;
  // shift multiplicand and multiplier
  logic step;
  // add multiplicand this step
  logic add_en;
  // apply sign correction
  logic fix;

  // multiplier lsb, back to control
  logic b_lsb;

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  // operand registers, accumulator, sign fix
  imul_dpath u_dpath (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .load   (load),
    .step   (step),
    .add_en (add_en),
    .fix    (fix),
    .b_lsb  (b_lsb),
    .resp   (resp)
  );

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  // owns both handshakes and the step count
  imul_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .b_lsb    (b_lsb),
    .load     (load),
    .step     (step),
    .add_en   (add_en),
    .fix      (fix)
  );

endmodule

/* rtl/imul_ctrl.sv */
/*
  three-state control for the iterative multiplier, fixed xlen calc cycles
  accepts a request only in idle, holds the response until resp_rdy
*/

module imul_ctrl (
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  logic resp_rdy,

  // from datapath
  input  logic b_lsb,

  // datapath strobes
  output logic load,
  output logic step,
  output logic add_en,
  output logic fix
);

  import imul_pkg::*;

  // --------------------------------------------------
  // state and counter
  // --------------------------------------------------

  mul_state_e        state_q;
  mul_state_e        state_d;
  logic [step_w-1:0] count_q;
  logic              last_step;
  logic              req_go;
  logic              resp_go;

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (count_q == step_w'(xlen - 1));

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_go) begin
          state_d = st_calc;
        end
      end
      st_calc: begin
        // leave after the final shift-add
        if (last_step) begin
          state_d = st_done;
        end
      end
      st_done: begin
        if (resp_go) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      // restart on accept, count up through calc
      if (req_go) begin
        count_q <= '0;
      end else if (state_q == st_calc) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // outputs, decoded from state
  // --------------------------------------------------

  assign req_rdy  = (state_q == st_idle);
  assign resp_val = (state_q == st_done);

  // load on the accepting edge
  assign load   = req_go;
  assign step   = (state_q == st_calc);
  // add only when the multiplier bit is set
  assign add_en = step && b_lsb;
  assign fix    = step && last_step;

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // handshakes never both open
  assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high together");

  // response is not withdrawn before it is taken
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val)
    else $error("resp_val dropped without resp_rdy");

  // fixed latency, xlen steps then done
  assert property (@(posedge clk) disable iff (reset)
    load |=> step [*32] ##1 (state_q == st_done))
    else $error("calc did not run exactly 32 steps");

endmodule

/* rtl/imul_dpath.sv */
/*
  shift-and-add datapath; works on magnitudes and fixes the sign on the last step
  load, step, add_en and fix come from the control unit, one operation at a time
*/

module imul_dpath (
  input  logic                clk,
  input  logic                reset,

  // operand pair, sampled on load
  input  imul_pkg::mul_req_t  req,

  // control strobes
  input  logic                load,
  input  logic                step,
  input  logic                add_en,
  input  logic                fix,

  // status back to control
  output logic                b_lsb,

  // product
  output imul_pkg::mul_resp_t resp
);

  import imul_pkg::*;

  // --------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------

  logic              sign_a;
  logic              sign_b;
  logic [xlen-1:0]   mag_a;
  logic [xlen-1:0]   mag_b;

  assign sign_a = req.a[xlen-1];
  assign sign_b = req.b[xlen-1];

  // two's complement when negative
  // most negative value maps onto itself and reads as 2**31 unsigned
  assign mag_a = sign_a ? (~req.a + 1'b1) : req.a;
  assign mag_b = sign_b ? (~req.b + 1'b1) : req.b;

  // --------------------------------------------------
  // iteration registers
  // --------------------------------------------------

  // multiplicand widened so it can shift left xlen times
  logic [prod_w-1:0] mcand_q;

  // multiplier shifts right and its lsb picks the add
  logic [xlen-1:0]   mplier_q;

  // result is negative when exactly one operand was
  logic              neg_q;

  // running sum
  logic [prod_w-1:0] acc_q;

  // capture magnitudes and sign on load, shift on every calc step
  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {{(prod_w - xlen){1'b0}}, mag_a};
      mplier_q <= mag_b;
      neg_q    <= sign_a ^ sign_b;
    end else if (step) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // current multiplier bit, control decides the add from it
  assign b_lsb = mplier_q[0];

  // --------------------------------------------------
  // accumulator
  // --------------------------------------------------

  logic [prod_w-1:0] acc_sum;
  logic [prod_w-1:0] acc_fixed;

  // partial product for this step
  assign acc_sum = add_en ? (acc_q + mcand_q) : acc_q;

  // sign correction applies to the sum of the same step
  assign acc_fixed = neg_q ? (~acc_sum + 1'b1) : acc_sum;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
    end else if (load) begin
      // fresh operation starts from zero
      acc_q <= '0;
    end else if (step) begin
      if (fix) begin
        acc_q <= acc_fixed;
      end else begin
        acc_q <= acc_sum;
      end
    end
  end

  // result held stable until the next load
  assign resp.result = acc_q;

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // the sign fix only lands on a calc step
  // an add outside calc would corrupt the held result
  assert property (@(posedge clk) disable iff (reset)
    (fix || add_en) |-> step)
    else $error("dpath strobe outside a calc step");

  // load and step never overlap since load would win and drop a step
  assert property (@(posedge clk) disable iff (reset)
    !(load && step))
    else $error("load and step asserted together");

endmodule

/* rtl/imul_pkg.sv */
/*
  shared widths, message structs and control state for the iterative multiplier
  operands are signed two's complement, product is full width with no truncation
*/

package imul_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // operand width
  localparam int xlen = 32;

  // full product width, no overflow possible
  localparam int prod_w = 2 * xlen;

  // step counter covers xlen steps, 0 to xlen-1
  localparam int step_w = 5;

  // --------------------------------------------------
  // request and response messages
  // --------------------------------------------------

  // operand pair, both signed
  typedef struct packed {
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } mul_req_t;

  // signed product
  typedef struct packed {
    logic [prod_w-1:0] result;
  } mul_resp_t;

  // --------------------------------------------------
  // control unit state
  // --------------------------------------------------

  // idle waits for a request, calc runs the steps, done holds the result
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } mul_state_e;

endpackage
